//--- correlator_top.f
corr_sample_pkg.sv
corr_acc_pkg.sv
line_sampler.sv
baseline_correlator.sv
result_readout.sv
correlator_top.sv
tb_clock_gen.sv
tb_correlator.sv

//--- run_sim.sh
#!/bin/sh
# Compile the correlator testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f correlator_top.f \
	--top-module tb_correlator \
	-o tb_correlator

# A failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/tb_correlator

//--- tb_correlator.sv
/* Correlator testbench
 * Table driven stimulus checked against a reference model of the line pairs
 */

`timescale 1ns/1ps

module tb_correlator;

	import corr_sample_pkg::*;
	import corr_acc_pkg::*;

	localparam int NUM_INPUTS = 4;
	localparam int NUM_BASELINES = 4;
	localparam int NUM_ROWS = 10;
	// Largest positive accumulator minus the largest product 15 * 15
	localparam int LIMIT_REF = 32767 - 225;

	typedef struct packed {
		logic [NUM_INPUTS-1:0]     mask;
		logic [NUM_BASELINES-1:0]  mode;
		tap_idx_t [NUM_INPUTS-1:0] delays;
		logic                      enable;
		logic                      all_max;
		logic                      snap_first;
		int                        count;
	} row_t;

	logic                      clk;
	logic                      reset;
	logic                      enable;
	logic [NUM_INPUTS-1:0]     strobe;
	sample_t [NUM_INPUTS-1:0]  adc;
	tap_idx_t [NUM_INPUTS-1:0] delay;
	logic [NUM_BASELINES-1:0]  mode;
	logic                      snapshot;
	logic [1:0]                sel;
	acc_pair_t                 result;
	logic                      result_valid;

	row_t        rows [NUM_ROWS];
	int          model_taps [NUM_INPUTS][DEPTH];
	int          acc_i [NUM_BASELINES];
	int          acc_q [NUM_BASELINES];
	int          saved_i [NUM_BASELINES];
	int          saved_q [NUM_BASELINES];
	logic [15:0] lfsr_state = 16'd43;
	int          cycle_count = 0;
	int          timeout_limit = 0;

	tb_clock_gen i_clock_gen (
		.clk     (clk),
		.reset_o (reset)
	);

	correlator_top #(
		.NUM_INPUTS    (NUM_INPUTS),
		.NUM_BASELINES (NUM_BASELINES)
	) i_dut (
		.clk            (clk),
		.reset_i        (reset),
		.enable_i       (enable),
		.strobe_i       (strobe),
		.adc_i          (adc),
		.delay_i        (delay),
		.mode_i         (mode),
		.snapshot_i     (snapshot),
		.sel_i          (sel),
		.result_o       (result),
		.result_valid_o (result_valid)
	);

	// ####################################################################
	// Stimulus table
	// ####################################################################

	task automatic load_table();
		// mask, mode, delays of lines 3..0, enable, samples at 15, early snapshot, steps
		rows[0] = '{4'h0, 4'h0, {3'd0, 3'd0, 3'd0, 3'd0}, 1'b1, 1'b0, 1'b0, 0};
		rows[1] = '{4'hF, 4'hF, {3'd2, 3'd7, 3'd4, 3'd1}, 1'b1, 1'b0, 1'b0, 12};
		rows[2] = '{4'hF, 4'hF, {3'd6, 3'd5, 3'd0, 3'd3}, 1'b1, 1'b0, 1'b0, 10};
		rows[3] = '{4'hF, 4'h0, {3'd1, 3'd1, 3'd1, 3'd1}, 1'b0, 1'b0, 1'b0, 5};
		rows[4] = '{4'hF, 4'h0, {3'd7, 3'd3, 3'd6, 3'd2}, 1'b1, 1'b0, 1'b0, 14};
		// Lines 1 and 3 stay idle
		rows[5] = '{4'h5, 4'hA, {3'd4, 3'd2, 3'd7, 3'd5}, 1'b1, 1'b0, 1'b0, 9};
		rows[6] = '{4'h3, 4'hF, {3'd3, 3'd6, 3'd1, 3'd4}, 1'b1, 1'b0, 1'b1, 6};
		rows[7] = '{4'hF, 4'hF, {3'd0, 3'd0, 3'd0, 3'd0}, 1'b0, 1'b0, 1'b0, 3};
		rows[8] = '{4'hF, 4'hF, {3'd5, 3'd2, 3'd7, 3'd3}, 1'b1, 1'b1, 1'b0, 160};
		rows[9] = '{4'hF, 4'hF, {3'd5, 3'd2, 3'd7, 3'd3}, 1'b1, 1'b1, 1'b0, 20};
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic draw_sample(output sample_t s);
		for (int k = 0; k < SAMPLE_W; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			s[k] = lfsr_state[0];
		end
	endtask

	function automatic int pair_term(input int a, input int b, input logic mul);
		if (mul)
			return a * b;
		return a - b;
	endfunction

	task automatic check_value(input string name, input logic signed [31:0] got,
			input logic signed [31:0] expected);
		if (got !== expected) begin
			$display("error: %s got %h expected %h", name, got, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ####################################################################
	// Driving and reference model
	// ####################################################################

	task automatic apply_step(input row_t row);
		sample_t s;
		int f;
		int sc;
		int d;
		for (int l = 0; l < NUM_INPUTS; l++) begin
			if (row.all_max)
				s = '1;
			else
				draw_sample(s);
			adc[l] = s;
			if (row.mask[l]) begin
				strobe[l] = ~strobe[l];
				for (int t = DEPTH - 1; t > 0; t--)
					model_taps[l][t] = model_taps[l][t-1];
				model_taps[l][0] = int'(s);
			end
		end
		// Only baselines whose first line took a sample move on
		for (int b = 0; b < NUM_BASELINES; b++) begin
			f = b % NUM_INPUTS;
			sc = (b + b / NUM_INPUTS + 1) % NUM_INPUTS;
			d = int'(row.delays[sc]);
			if (row.enable && row.mask[f] &&
					acc_i[b] < LIMIT_REF && acc_q[b] < LIMIT_REF) begin
				acc_i[b] += pair_term(model_taps[f][0], model_taps[sc][d / 2], row.mode[b]);
				acc_q[b] += pair_term(model_taps[f][0], model_taps[sc][d], row.mode[b]);
			end
		end
		@(negedge clk);
	endtask

	task automatic take_snapshot();
		snapshot = 1'b1;
		@(negedge clk);
		snapshot = 1'b0;
	endtask

	task automatic read_all(input logic use_saved);
		acc_t got;
		for (int b = 0; b < NUM_BASELINES; b++) begin
			sel = 2'(b);
			@(negedge clk);
			check_value("result_valid_o", result_valid, 1);
			got = result.i;
			check_value($sformatf("result_o.i[%0d]", b), got,
				use_saved ? saved_i[b] : acc_i[b]);
			got = result.q;
			check_value($sformatf("result_o.q[%0d]", b), got,
				use_saved ? saved_q[b] : acc_q[b]);
		end
	endtask

	task automatic run_row(input row_t row);
		if (row.snap_first) begin
			take_snapshot();
			saved_i = acc_i;
			saved_q = acc_q;
		end
		enable = row.enable;
		mode = row.mode;
		delay = row.delays;
		if (!row.enable) begin
			acc_i = '{default: 0};
			acc_q = '{default: 0};
		end
		repeat (row.count)
			apply_step(row);
		// Bank still holds the values from before these strobes
		if (row.snap_first)
			read_all(1'b1);
		repeat (4)
			@(negedge clk);
		take_snapshot();
		read_all(1'b0);
	endtask

	// ####################################################################
	// Timeout and main sequence
	// ####################################################################

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("Timeout: run exceeded %0d cycles", timeout_limit);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		enable = 1'b0;
		strobe = '0;
		adc = '0;
		delay = '0;
		mode = '0;
		snapshot = 1'b0;
		sel = '0;
		load_table();
		timeout_limit = 100;
		for (int r = 0; r < NUM_ROWS; r++)
			timeout_limit += 2 * rows[r].count + 20;
		@(negedge reset);
		@(negedge clk);
		check_value("result_valid_o", result_valid, 0);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(rows[r]);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- tb_clock_gen.sv
/* Testbench clock and reset
 * 10 ns clock, reset held high for the first 4 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 5,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset_o
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		// Release away from the sampling edge
		@(negedge clk);
		reset_o = 1'b0;
	end

endmodule

//--- correlator_top.sv
/* Correlator top level
 * Line samplers feeding pairwise baselines and a snapshot readout
 */

`timescale 1ns/1ps

module correlator_top #(
	parameter int NUM_INPUTS = 4,
	parameter int NUM_BASELINES = 4,
	localparam int SEL_W = (NUM_BASELINES > 1) ? $clog2(NUM_BASELINES) : 1
) (
	input  logic                                       clk,
	input  logic                                       reset_i,
	input  logic                                       enable_i,
	input  logic [NUM_INPUTS-1:0]                      strobe_i,
	input  corr_sample_pkg::sample_t [NUM_INPUTS-1:0]  adc_i,
	input  corr_sample_pkg::tap_idx_t [NUM_INPUTS-1:0] delay_i,
	input  logic [NUM_BASELINES-1:0]                   mode_i,
	input  logic                                       snapshot_i,
	input  logic [SEL_W-1:0]                           sel_i,
	output corr_acc_pkg::acc_pair_t                    result_o,
	output logic                                       result_valid_o
);

	import corr_sample_pkg::*;
	import corr_acc_pkg::*;

	line_taps_t [NUM_INPUTS-1:0]   line_taps;
	logic [NUM_INPUTS-1:0]         line_new;
	acc_pair_t [NUM_BASELINES-1:0] baseline_acc;

	// ####################################################################
	// Input lines
	// ####################################################################

	for (genvar l = 0; l < NUM_INPUTS; l++) begin : g_line
		line_sampler i_sampler (
			.clk      (clk),
			.reset_i  (reset_i),
			.strobe_i (strobe_i[l]),
			.sample_i (adc_i[l]),
			.taps_o   (line_taps[l]),
			.new_o    (line_new[l])
		);
	end

	// ####################################################################
	// Baselines
	// ####################################################################

	for (genvar b = 0; b < NUM_BASELINES; b++) begin : g_baseline
		// Pairing wraps around and widens the stride every NUM_INPUTS baselines
		localparam int FIRST = b % NUM_INPUTS;
		localparam int SECOND = (b + b / NUM_INPUTS + 1) % NUM_INPUTS;

		baseline_correlator i_corr (
			.clk           (clk),
			.reset_i       (reset_i),
			.enable_i      (enable_i),
			.mode_i        (mode_i[b]),
			.new_i         (line_new[FIRST]),
			.first_taps_i  (line_taps[FIRST]),
			.second_taps_i (line_taps[SECOND]),
			.delay_i       (delay_i[SECOND]),
			.acc_o         (baseline_acc[b])
		);
	end

	result_readout #(
		.NUM_BASELINES (NUM_BASELINES)
	) i_readout (
		.clk            (clk),
		.reset_i        (reset_i),
		.snapshot_i     (snapshot_i),
		.sel_i          (sel_i),
		.acc_i          (baseline_acc),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

endmodule

//--- result_readout.sv
/* Result readout
 * Freezes all accumulator pairs on a snapshot and presents one by index
 */

`timescale 1ns/1ps

module result_readout #(
	parameter int NUM_BASELINES = 4,
	localparam int SEL_W = (NUM_BASELINES > 1) ? $clog2(NUM_BASELINES) : 1
) (
	input  logic                                        clk,
	input  logic                                        reset_i,
	input  logic                                        snapshot_i,
	input  logic [SEL_W-1:0]                            sel_i,
	input  corr_acc_pkg::acc_pair_t [NUM_BASELINES-1:0] acc_i,
	output corr_acc_pkg::acc_pair_t                     result_o,
	output logic                                        result_valid_o
);

	import corr_acc_pkg::*;

	acc_pair_t [NUM_BASELINES-1:0] bank_q;

	// Set by the first snapshot after reset
	logic snap_seen_q;

	// ####################################################################
	// Snapshot bank
	// ####################################################################

	always_ff @(posedge clk) begin
		if (snapshot_i) begin
			bank_q <= acc_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			snap_seen_q <= 1'b0;
			result_o <= '0;
			result_valid_o <= 1'b0;
		end else begin
			if (snapshot_i)
				snap_seen_q <= 1'b1;
			result_valid_o <= snap_seen_q;
			// Bank holds nothing useful before the first snapshot
			if (snap_seen_q && (sel_i < NUM_BASELINES))
				result_o <= bank_q[sel_i];
			else
				result_o <= '0;
		end
	end

endmodule

//--- baseline_correlator.sv
/* Baseline correlator
 * Forms I and Q terms of a line pair and accumulates them until the limit
 */

`timescale 1ns/1ps

module baseline_correlator (
	input  logic                        clk,
	input  logic                        reset_i,
	input  logic                        enable_i,
	input  logic                        mode_i,
	input  logic                        new_i,
	input  corr_sample_pkg::line_taps_t first_taps_i,
	input  corr_sample_pkg::line_taps_t second_taps_i,
	input  corr_sample_pkg::tap_idx_t   delay_i,
	output corr_acc_pkg::acc_pair_t     acc_o
);

	import corr_sample_pkg::*;
	import corr_acc_pkg::*;

	sample_t  first_new;
	sample_t  half_tap;
	sample_t  full_tap;
	tap_idx_t half_delay;

	term_t term_i_q;
	term_t term_q_q;
	logic  term_valid_q;

	logic     below_limit;
	acc_pair_t acc_q;

	// Product when mul is set, otherwise a minus b
	function automatic term_t combine(input sample_t a, input sample_t b, input logic mul);
		term_t ext_a;
		term_t ext_b;
		ext_a = term_t'(a);
		ext_b = term_t'(b);
		if (mul)
			return ext_a * ext_b;
		else
			return ext_a - ext_b;
	endfunction

	// ####################################################################
	// Tap selection
	// ####################################################################

	assign half_delay = delay_i >> 1;
	assign first_new = first_taps_i.tap[0];
	assign half_tap = second_taps_i.tap[half_delay];
	assign full_tap = second_taps_i.tap[delay_i];

	// Stage 1 registers the terms of the newest sample
	always_ff @(posedge clk) begin
		if (reset_i || !enable_i) begin
			term_valid_q <= 1'b0;
		end else begin
			term_valid_q <= new_i;
		end
	end

	always_ff @(posedge clk) begin
		if (new_i) begin
			term_i_q <= combine(first_new, half_tap, mode_i);
			term_q_q <= combine(first_new, full_tap, mode_i);
		end
	end

	// ####################################################################
	// Accumulation
	// ####################################################################

	// Both sides freeze as soon as one of them hits the limit
	assign below_limit = (acc_q.i < ACC_LIMIT) && (acc_q.q < ACC_LIMIT);

	always_ff @(posedge clk) begin
		if (reset_i || !enable_i) begin
			acc_q <= '0;
		end else if (term_valid_q && below_limit) begin
			acc_q.i <= acc_q.i + acc_t'(term_i_q);
			acc_q.q <= acc_q.q + acc_t'(term_q_q);
		end
	end

	assign acc_o = acc_q;

endmodule

//--- line_sampler.sv
/* Line sampler
 * Captures one sample per strobe level change and shifts the delay line
 */

`timescale 1ns/1ps

module line_sampler (
	input  logic                        clk,
	input  logic                        reset_i,
	input  logic                        strobe_i,
	input  corr_sample_pkg::sample_t    sample_i,
	output corr_sample_pkg::line_taps_t taps_o,
	output logic                        new_o
);

	import corr_sample_pkg::*;

	// Last strobe level seen
	logic strobe_q;

	line_taps_t taps_q;
	logic       change;

	// Either edge of the strobe marks a new sample
	assign change = (strobe_i != strobe_q);

	// ####################################################################
	// Strobe tracking and delay line
	// ####################################################################

	always_ff @(posedge clk) begin
		if (reset_i) begin
			strobe_q <= 1'b0;
			taps_q <= '0;
			new_o <= 1'b0;
		end else begin
			new_o <= change;
			if (change) begin
				strobe_q <= strobe_i;
				// Oldest tap drops out at the top
				taps_q.tap <= {taps_q.tap[DEPTH-2:0], sample_i};
			end
		end
	end

	assign taps_o = taps_q;

endmodule

//--- corr_acc_pkg.sv
/* Correlation side types
 * Signed terms, accumulator pairs and the accumulation limit
 */

package corr_acc_pkg;

	localparam int TERM_W = 10;
	localparam int ACC_W = 16;

	typedef logic signed [TERM_W-1:0] term_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// ####################################################################
	// Result of one baseline
	// ####################################################################

	typedef struct packed {
		acc_t i;
		acc_t q;
	} acc_pair_t;

	// Largest term a single sample pair can add
	localparam int MAX_PRODUCT = ((1 << corr_sample_pkg::SAMPLE_W) - 1) ** 2;

	// Below this value one more term can never overflow
	localparam acc_t ACC_LIMIT = acc_t'((2 ** (ACC_W - 1)) - 1 - MAX_PRODUCT);

endpackage

//--- corr_sample_pkg.sv
/* Input side types for the correlator
 * Samples, tap indices and the per-line delay line
 */

package corr_sample_pkg;

	// Sample width and taps per delay line
	localparam int SAMPLE_W = 4;
	localparam int DEPTH = 8;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// Delay in taps, wide enough to address every tap
	typedef logic [$clog2(DEPTH)-1:0] tap_idx_t;

	// ####################################################################
	// Delay line of one input
	// ####################################################################

	// Tap 0 holds the newest sample
	typedef struct packed {
		sample_t [DEPTH-1:0] tap;
	} line_taps_t;

endpackage
